//--- sim.f
hdl/exec_pkg.sv
hdl/alu_core.sv
hdl/mul_unit.sv
hdl/div_unit.sv
hdl/exec_ctrl.sv
hdl/exec_unit.sv
verification/exec_unit_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" \
    && verilator --binary --timing --timescale 1ns/1ps \
        -f sim.f --top-module exec_unit_tb -o exec_unit_tb \
    && ./obj_dir/exec_unit_tb \
    || { echo "simulation run did not complete cleanly"; exit 1; }

//--- verification/exec_unit_tb.sv
module exec_unit_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import exec_pkg::*;

    localparam int xlen            = 64;
    localparam int half            = xlen / 2;
    localparam int shamt_w         = $clog2(xlen);
    localparam int ack_timeout     = 200;
    localparam int release_timeout = 4;
    localparam int flush_hold      = 100;
    localparam int num_random      = 40;

    typedef logic [xlen-1:0] word_t;

    typedef struct packed {
        alu_op_t op;
        src_a_t  sel_a;
        src_b_t  sel_b;
        logic    w32;
        word_t   pc;
        word_t   rs1;
        word_t   rs2;
        word_t   csr;
        word_t   imm;
        word_t   exp;
    } row_t;

    localparam word_t min_val  = {1'b1, {(xlen-1){1'b0}}};
    localparam word_t all_ones = '1;
    localparam word_t def_pc   = 'h1000;
    localparam word_t def_csr  = 'h77;
    localparam word_t def_imm  = 'h5;

    logic    clk;
    logic    rst;
    logic    flush;
    logic    req;
    alu_op_t op;
    src_a_t  sel_a;
    src_b_t  sel_b;
    logic    w32;
    word_t   pc;
    word_t   rs1;
    word_t   rs2;
    word_t   csr;
    word_t   imm;
    logic    ack;
    word_t   res;

    logic [31:0] rng_state = 32'hc0d5dd60;
    row_t        rows[$];

    exec_unit #(
        .xlen (xlen)
    ) i_dut (
        .clk   (clk),
        .rst   (rst),
        .flush (flush),
        .req   (req),
        .op    (op),
        .sel_a (sel_a),
        .sel_b (sel_b),
        .w32   (w32),
        .pc    (pc),
        .rs1   (rs1),
        .rs2   (rs2),
        .csr   (csr),
        .imm   (imm),
        .ack   (ack),
        .res   (res)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic is_iterative(input alu_op_t o);
        return o inside {op_mul, op_div, op_divu, op_rem, op_remu};
    endfunction

    // expected result from the operation rules
    function automatic word_t model_result(input row_t r);
        word_t              a;
        word_t              b;
        word_t              x;
        logic [shamt_w-1:0] sh;
        logic [half-1:0]    lo;
        logic               div_zero;
        logic               overflow;
        x = r.w32 ? {{half{1'b0}}, r.rs1[half-1:0]} : r.rs1;
        a = (r.sel_a == src_a_rs1) ? x : r.pc;
        if (r.sel_b == src_b_rs2) begin
            b = r.rs2;
        end else if (r.sel_b == src_b_csr) begin
            b = r.csr;
        end else begin
            b = r.imm;
        end
        sh = b[shamt_w-1:0];
        div_zero = (b == '0);
        overflow = (a == min_val) && (b == all_ones);
        case (r.op)
            op_add:    return a + b;
            op_sub:    return a - b;
            op_pass_a: return a;
            op_pass_b: return b;
            op_xor:    return a ^ b;
            op_or:     return a | b;
            op_and:    return a & b;
            op_sll:    return a << sh;
            op_srl:    return a >> sh;
            op_sra: begin
                // word mode shifts the signed low half and leaves the upper half zero
                if (r.w32) begin
                    lo = $signed(a[half-1:0]) >>> sh;
                    return {{half{1'b0}}, lo};
                end
                return $signed(a) >>> sh;
            end
            op_slt:    return ($signed(a) < $signed(b)) ? word_t'(1) : '0;
            op_sltu:   return (a < b) ? word_t'(1) : '0;
            op_eq:     return (a == b) ? word_t'(1) : '0;
            op_ge:     return ($signed(a) >= $signed(b)) ? word_t'(1) : '0;
            op_geu:    return (a >= b) ? word_t'(1) : '0;
            op_mul:    return a * b;
            op_div: begin
                if (div_zero) begin
                    return all_ones;
                end
                if (overflow) begin
                    return a;
                end
                return $signed(a) / $signed(b);
            end
            op_rem: begin
                if (div_zero) begin
                    return a;
                end
                if (overflow) begin
                    return '0;
                end
                return $signed(a) % $signed(b);
            end
            op_divu:   return div_zero ? all_ones : a / b;
            op_remu:   return div_zero ? a : a % b;
            default:   return '0;
        endcase
    endfunction

    task automatic report_error(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_res(input word_t got, input word_t exp, input alu_op_t o);
        if (got !== exp) begin
            report_error($sformatf("Fail at %0t: res %h for %s, expected %h",
                                   $time, got, o.name(), exp));
        end
    endtask

    task automatic check_ack(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_error($sformatf("Fail at %0t: ack is %0b, %s", $time, got, what));
        end
    endtask

    task automatic check_latency(input int got, input int exp, input alu_op_t o);
        if (got != exp) begin
            report_error($sformatf("Fail at %0t: ack for %s after %0d cycles, expected %0d",
                                   $time, o.name(), got, exp));
        end
    endtask

    function automatic row_t make_row(input alu_op_t o, input src_a_t sa, input src_b_t sb,
                                      input logic w, input word_t x, input word_t y);
        row_t r;
        r.op    = o;
        r.sel_a = sa;
        r.sel_b = sb;
        r.w32   = w;
        r.pc    = def_pc;
        r.rs1   = x;
        r.rs2   = y;
        r.csr   = def_csr;
        r.imm   = def_imm;
        r.exp   = model_result(r);
        return r;
    endfunction

    // directed row with a hand-written expected value
    task automatic add_row(input alu_op_t o, input src_a_t sa, input src_b_t sb,
                           input logic w, input word_t x, input word_t y, input word_t e);
        row_t r;
        r = make_row(o, sa, sb, w, x, y);
        r.exp = e;
        rows.push_back(r);
    endtask

    task automatic add_rr(input alu_op_t o, input word_t x, input word_t y, input word_t e);
        add_row(o, src_a_rs1, src_b_rs2, 1'b0, x, y, e);
    endtask

    task automatic build_directed();
        add_rr(op_add, 'h5, 'h7, 'hc);
        add_rr(op_sub, 'h5, 'h7, 64'hFFFF_FFFF_FFFF_FFFE);
        add_rr(op_pass_a, 'h1234, 'h0, 'h1234);
        add_rr(op_pass_b, 'h0, 'hABCD, 'hABCD);
        add_rr(op_xor, 'hF0F0, 'hFF00, 'h0FF0);
        add_rr(op_or, 'hF0F0, 'h0F0F, 'hFFFF);
        add_rr(op_and, 'hF0F0, 'hFF00, 'hF000);
        // shifts by 0, 1 and 63 with the amount taken from the low six bits
        add_rr(op_sll, 64'h8000_0000_0000_0001, 'h0, 64'h8000_0000_0000_0001);
        add_rr(op_sll, 'h3, 'h1, 'h6);
        add_rr(op_sll, 'h3, 'h3F, min_val);
        add_rr(op_sll, 'h3, 'h41, 'h6);
        add_rr(op_srl, min_val, 'h1, 64'h4000_0000_0000_0000);
        add_rr(op_srl, min_val, 'h3F, 'h1);
        add_rr(op_srl, 'h10, 'h102, 'h4);
        add_rr(op_sra, min_val, 'h1, 64'hC000_0000_0000_0000);
        add_rr(op_sra, min_val, 'h3F, all_ones);
        add_rr(op_sra, 64'h4000_0000_0000_0000, 'h0, 64'h4000_0000_0000_0000);
        add_rr(op_slt, all_ones, 'h1, 'h1);
        add_rr(op_sltu, all_ones, 'h1, 'h0);
        add_rr(op_eq, 'h55, 'h55, 'h1);
        add_rr(op_eq, 'h55, 'h56, 'h0);
        add_rr(op_ge, 'h1, all_ones, 'h1);
        add_rr(op_ge, 'h7, 'h7, 'h1);
        add_rr(op_geu, 'h1, all_ones, 'h0);
        // operand sources and word mode
        add_row(op_pass_a, src_a_pc, src_b_rs2, 1'b0, 'h9, 'h0, def_pc);
        add_row(op_pass_b, src_a_rs1, src_b_csr, 1'b0, 'h9, 'h8, def_csr);
        add_row(op_pass_b, src_a_rs1, src_b_imm, 1'b0, 'h9, 'h8, def_imm);
        add_row(op_add, src_a_pc, src_b_imm, 1'b0, 'h9, 'h8, 'h1005);
        add_row(op_add, src_a_pc, src_b_csr, 1'b0, 'h9, 'h8, 'h1077);
        add_row(op_pass_a, src_a_rs1, src_b_rs2, 1'b1, 64'hDEAD_BEEF_8765_4321, 'h0,
                64'h0000_0000_8765_4321);
        add_row(op_add, src_a_rs1, src_b_rs2, 1'b1, 64'hFFFF_FFFF_0000_0010, 'h1, 'h11);
        add_row(op_sra, src_a_rs1, src_b_rs2, 1'b1, 64'hFFFF_FFFF_8000_0000, 'h4,
                64'h0000_0000_F800_0000);
        // multiplier returns the low word only
        add_rr(op_mul, 'h6, 'h7, 'h2a);
        add_rr(op_mul, all_ones, all_ones, 'h1);
        add_rr(op_mul, min_val, 'h3, min_val);
        add_rr(op_mul, 'h0, 'h1234, 'h0);
        // divider with mixed signs and the corner cases
        add_rr(op_div, 64'hFFFF_FFFF_FFFF_FFF9, 'h2, 64'hFFFF_FFFF_FFFF_FFFD);
        add_rr(op_rem, 64'hFFFF_FFFF_FFFF_FFF9, 'h2, all_ones);
        add_rr(op_div, 'h7, 64'hFFFF_FFFF_FFFF_FFFE, 64'hFFFF_FFFF_FFFF_FFFD);
        add_rr(op_rem, 'h7, 64'hFFFF_FFFF_FFFF_FFFE, 'h1);
        add_rr(op_divu, 64'hFFFF_FFFF_FFFF_FFF9, 'h2, 64'h7FFF_FFFF_FFFF_FFFC);
        add_rr(op_remu, 64'hFFFF_FFFF_FFFF_FFF9, 'h2, 'h1);
        add_rr(op_div, 'h1234, 'h0, all_ones);
        add_rr(op_rem, 'h1234, 'h0, 'h1234);
        add_rr(op_divu, 'h1234, 'h0, all_ones);
        add_rr(op_remu, 'h1234, 'h0, 'h1234);
        add_rr(op_div, min_val, all_ones, min_val);
        add_rr(op_rem, min_val, all_ones, 'h0);
        add_rr(op_divu, min_val, all_ones, 'h0);
        add_rr(op_remu, min_val, all_ones, min_val);
    endtask

    task automatic build_random();
        row_t       r;
        logic [4:0] op_bits;
        logic [1:0] b_pick;
        for (int i = 0; i < num_random; i++) begin
            op_bits = 5'(next_rand() % 20);
            b_pick  = 2'(next_rand() % 3);
            r.op    = alu_op_t'(op_bits);
            r.sel_a = ((next_rand() & 32'h1) != 0) ? src_a_rs1 : src_a_pc;
            r.sel_b = (b_pick == 2'd0) ? src_b_rs2 : (b_pick == 2'd1) ? src_b_csr : src_b_imm;
            r.w32   = (next_rand() % 4) == 0;
            r.pc    = {next_rand(), next_rand()};
            r.rs1   = {next_rand(), next_rand()};
            r.rs2   = {next_rand(), next_rand()};
            r.csr   = {next_rand(), next_rand()};
            r.imm   = {next_rand(), next_rand()};
            // small divisors now and then including zero
            if ((next_rand() % 4) == 0) begin
                r.rs2 = word_t'(next_rand() & 32'hff);
            end
            r.exp = model_result(r);
            rows.push_back(r);
        end
    endtask

    // one four-phase transaction with req held hold extra cycles after ack
    task automatic run_row(input row_t r, input int hold);
        int      cycles;
        alu_op_t cur_op;
        cur_op = r.op;
        @(posedge clk);
        req   <= 1'b1;
        op    <= r.op;
        sel_a <= r.sel_a;
        sel_b <= r.sel_b;
        w32   <= r.w32;
        pc    <= r.pc;
        rs1   <= r.rs1;
        rs2   <= r.rs2;
        csr   <= r.csr;
        imm   <= r.imm;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > ack_timeout) begin
                report_error($sformatf("timeout, no ack within %0d cycles for %s",
                                       ack_timeout, cur_op.name()));
            end
        end while (!ack);
        // req sampled on the first edge and ack one edge later
        if (!is_iterative(cur_op)) begin
            check_latency(cycles, 3, cur_op);
        end
        check_res(res, r.exp, cur_op);
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            check_ack(ack, 1'b1, "dropped while req was still high");
            check_res(res, r.exp, cur_op);
        end
        @(posedge clk);
        req <= 1'b0;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > release_timeout) begin
                report_error($sformatf("timeout, ack did not fall within %0d cycles of req low",
                                       release_timeout));
            end
        end while (ack);
    endtask

    // abort an iterative op in flight and keep req high without an ack
    task automatic flush_in_flight(input alu_op_t o, input word_t x, input word_t y);
        @(posedge clk);
        req   <= 1'b1;
        op    <= o;
        sel_a <= src_a_rs1;
        sel_b <= src_b_rs2;
        w32   <= 1'b0;
        rs1   <= x;
        rs2   <= y;
        repeat (8) @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        repeat (flush_hold) begin
            @(negedge clk);
            check_ack(ack, 1'b0, "raised after a flush");
        end
        @(posedge clk);
        req <= 1'b0;
        @(posedge clk);
    endtask

    initial begin
        int hold;
        rst   <= 1'b1;
        flush <= 1'b0;
        req   <= 1'b0;
        op    <= op_add;
        sel_a <= src_a_rs1;
        sel_b <= src_b_rs2;
        w32   <= 1'b0;
        pc    <= '0;
        rs1   <= '0;
        rs2   <= '0;
        csr   <= '0;
        imm   <= '0;
        build_directed();
        build_random();
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_ack(ack, 1'b0, "high after reset");
        foreach (rows[i]) begin
            hold = int'(next_rand() % 6);
            run_row(rows[i], hold);
        end
        flush_in_flight(op_mul, 64'h0123_4567_89AB_CDEF, 64'hFEDC_BA98_7654_3210);
        run_row(make_row(op_mul, src_a_rs1, src_b_rs2, 1'b0, 'h11, 'h13), 0);
        flush_in_flight(op_div, 64'h7FFF_0000_1234_5678, 'h3);
        run_row(make_row(op_rem, src_a_rs1, src_b_rs2, 1'b0, 'h64, 'h7), 2);
        $display("Testbench passed");
        $finish;
    end

endmodule

//--- hdl/exec_unit.sv
module exec_unit #(
    parameter int xlen = 64
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  logic              req,
    input  exec_pkg::alu_op_t op,
    input  exec_pkg::src_a_t  sel_a,
    input  exec_pkg::src_b_t  sel_b,
    input  logic              w32,
    input  logic [xlen-1:0]   pc,
    input  logic [xlen-1:0]   rs1,
    input  logic [xlen-1:0]   rs2,
    input  logic [xlen-1:0]   csr,
    input  logic [xlen-1:0]   imm,
    output logic              ack,
    output logic [xlen-1:0]   res
);
    import exec_pkg::*;

    typedef logic [xlen-1:0] word_t;

    // captured request
    alu_op_t cap_op;
    src_a_t  cap_sel_a;
    src_b_t  cap_sel_b;
    logic    cap_w32;
    word_t   cap_pc;
    word_t   cap_rs1;
    word_t   cap_rs2;
    word_t   cap_csr;
    word_t   cap_imm;

    // alu_core outputs
    word_t   alu_a;
    word_t   alu_b;
    word_t   alu_res;

    // iterative unit handshakes
    word_t   op_a;
    word_t   op_b;
    logic    mul_start;
    logic    div_start;
    logic    abort;
    logic    is_signed;
    logic    want_rem;
    logic    mul_done;
    logic    div_done;
    word_t   mul_res;
    word_t   div_res;

    exec_ctrl #(
        .xlen (xlen)
    ) i_ctrl (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .req       (req),
        .op        (op),
        .sel_a     (sel_a),
        .sel_b     (sel_b),
        .w32       (w32),
        .pc        (pc),
        .rs1       (rs1),
        .rs2       (rs2),
        .csr       (csr),
        .imm       (imm),
        .alu_a     (alu_a),
        .alu_b     (alu_b),
        .alu_res   (alu_res),
        .mul_done  (mul_done),
        .mul_res   (mul_res),
        .div_done  (div_done),
        .div_res   (div_res),
        .ack       (ack),
        .res       (res),
        .cap_op    (cap_op),
        .cap_sel_a (cap_sel_a),
        .cap_sel_b (cap_sel_b),
        .cap_w32   (cap_w32),
        .cap_pc    (cap_pc),
        .cap_rs1   (cap_rs1),
        .cap_rs2   (cap_rs2),
        .cap_csr   (cap_csr),
        .cap_imm   (cap_imm),
        .mul_start (mul_start),
        .div_start (div_start),
        .abort     (abort),
        .is_signed (is_signed),
        .want_rem  (want_rem),
        .op_a      (op_a),
        .op_b      (op_b)
    );

    alu_core #(
        .xlen (xlen)
    ) i_alu (
        .op    (cap_op),
        .sel_a (cap_sel_a),
        .sel_b (cap_sel_b),
        .w32   (cap_w32),
        .pc    (cap_pc),
        .rs1   (cap_rs1),
        .rs2   (cap_rs2),
        .csr   (cap_csr),
        .imm   (cap_imm),
        .a     (alu_a),
        .b     (alu_b),
        .res   (alu_res)
    );

    mul_unit #(
        .xlen (xlen)
    ) i_mul (
        .clk   (clk),
        .rst   (rst),
        .start (mul_start),
        .abort (abort),
        .a     (op_a),
        .b     (op_b),
        .done  (mul_done),
        .res   (mul_res)
    );

    div_unit #(
        .xlen (xlen)
    ) i_div (
        .clk       (clk),
        .rst       (rst),
        .start     (div_start),
        .abort     (abort),
        .is_signed (is_signed),
        .want_rem  (want_rem),
        .a         (op_a),
        .b         (op_b),
        .done      (div_done),
        .res       (div_res)
    );

endmodule

//--- hdl/exec_ctrl.sv
module exec_ctrl #(
    parameter int xlen = 64
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  logic              req,
    input  exec_pkg::alu_op_t op,
    input  exec_pkg::src_a_t  sel_a,
    input  exec_pkg::src_b_t  sel_b,
    input  logic              w32,
    input  logic [xlen-1:0]   pc,
    input  logic [xlen-1:0]   rs1,
    input  logic [xlen-1:0]   rs2,
    input  logic [xlen-1:0]   csr,
    input  logic [xlen-1:0]   imm,
    input  logic [xlen-1:0]   alu_a,
    input  logic [xlen-1:0]   alu_b,
    input  logic [xlen-1:0]   alu_res,
    input  logic              mul_done,
    input  logic [xlen-1:0]   mul_res,
    input  logic              div_done,
    input  logic [xlen-1:0]   div_res,
    output logic              ack,
    output logic [xlen-1:0]   res,
    output exec_pkg::alu_op_t cap_op,
    output exec_pkg::src_a_t  cap_sel_a,
    output exec_pkg::src_b_t  cap_sel_b,
    output logic              cap_w32,
    output logic [xlen-1:0]   cap_pc,
    output logic [xlen-1:0]   cap_rs1,
    output logic [xlen-1:0]   cap_rs2,
    output logic [xlen-1:0]   cap_csr,
    output logic [xlen-1:0]   cap_imm,
    output logic              mul_start,
    output logic              div_start,
    output logic              abort,
    output logic              is_signed,
    output logic              want_rem,
    output logic [xlen-1:0]   op_a,
    output logic [xlen-1:0]   op_b
);
    import exec_pkg::*;

    ctrl_state_t state;
    logic        req_seen_low;
    logic        launch;
    logic        accept;
    logic        cap_multi;

    // a flushed request must drop req before the next one is taken
    assign accept    = (state == st_idle) && req && req_seen_low;
    assign cap_multi = op_is_multi(cap_op);
    assign abort     = flush && (state == st_busy);
    assign is_signed = (cap_op == op_div) || (cap_op == op_rem);
    assign want_rem  = (cap_op == op_rem) || (cap_op == op_remu);

    // request fields stay put until the next accept
    always_ff @(posedge clk) begin
        if (accept) begin
            cap_op    <= op;
            cap_sel_a <= sel_a;
            cap_sel_b <= sel_b;
            cap_w32   <= w32;
            cap_pc    <= pc;
            cap_rs1   <= rs1;
            cap_rs2   <= rs2;
            cap_csr   <= csr;
            cap_imm   <= imm;
        end
    end

    // selected operands handed to the iterative units with the start pulse
    always_ff @(posedge clk) begin
        if ((state == st_busy) && launch && cap_multi) begin
            op_a <= alu_a;
            op_b <= alu_b;
        end
    end

    // result register, held through st_done
    always_ff @(posedge clk) begin
        if ((state == st_busy) && !flush) begin
            if (launch && !cap_multi) begin
                res <= alu_res;
            end else if (mul_done) begin
                res <= mul_res;
            end else if (div_done) begin
                res <= div_res;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= st_idle;
            ack          <= 1'b0;
            launch       <= 1'b0;
            mul_start    <= 1'b0;
            div_start    <= 1'b0;
            req_seen_low <= 1'b1;
        end else begin
            mul_start <= 1'b0;
            div_start <= 1'b0;
            if (!req) begin
                req_seen_low <= 1'b1;
            end
            case (state)
                st_idle: begin
                    if (accept) begin
                        state  <= st_busy;
                        launch <= 1'b1;
                    end
                end
                st_busy: begin
                    if (flush) begin
                        state        <= st_idle;
                        launch       <= 1'b0;
                        req_seen_low <= 1'b0;
                    end else if (launch) begin
                        launch <= 1'b0;
                        if (cap_multi) begin
                            mul_start <= (cap_op == op_mul);
                            div_start <= op_is_div(cap_op);
                        end else begin
                            ack   <= 1'b1;
                            state <= st_done;
                        end
                    end else if (mul_done || div_done) begin
                        ack   <= 1'b1;
                        state <= st_done;
                    end
                end
                st_done: begin
                    // back-pressure, wait for the requester to let go
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

//--- hdl/div_unit.sv
module div_unit #(
    parameter int xlen = 64
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    input  logic            abort,
    input  logic            is_signed,
    input  logic            want_rem,
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    output logic            done,
    output logic [xlen-1:0] res
);
    localparam int cnt_w = $clog2(xlen);

    typedef logic [xlen-1:0]  word_t;
    typedef logic [xlen:0]    wide_t;
    typedef logic [cnt_w-1:0] count_t;

    localparam word_t min_val = {1'b1, {(xlen-1){1'b0}}};

    word_t  dvs;
    word_t  quo;
    word_t  rem_r;
    word_t  abs_a;
    word_t  abs_b;
    count_t count;
    wide_t  shifted;
    wide_t  diff;
    logic   busy;
    logic   fixup;
    logic   neg_q;
    logic   neg_r;
    logic   rem_sel;
    logic   div_zero;
    logic   overflow;

    assign abs_a = (is_signed && a[xlen-1]) ? -a : a;
    assign abs_b = (is_signed && b[xlen-1]) ? -b : b;

    // riscv corner cases, answered without iterating
    assign div_zero = (b == '0);
    assign overflow = is_signed && (a == min_val) && (b == '1);

    // trial subtraction, msb of diff set means it did not fit
    assign shifted = {rem_r, quo[xlen-1]};
    assign diff    = shifted - {1'b0, dvs};

    always_ff @(posedge clk) begin
        if (start && !abort) begin
            quo     <= abs_a;
            rem_r   <= '0;
            dvs     <= abs_b;
            count   <= count_t'(xlen - 1);
            neg_q   <= is_signed && (a[xlen-1] ^ b[xlen-1]);
            neg_r   <= is_signed && a[xlen-1];
            rem_sel <= want_rem;
            if (div_zero) begin
                res <= want_rem ? a : '1;
            end else if (overflow) begin
                res <= want_rem ? '0 : a;
            end
        end else if (busy) begin
            if (diff[xlen]) begin
                rem_r <= shifted[xlen-1:0];
                quo   <= {quo[xlen-2:0], 1'b0};
            end else begin
                rem_r <= diff[xlen-1:0];
                quo   <= {quo[xlen-2:0], 1'b1};
            end
            count <= count - count_t'(1);
        end else if (fixup) begin
            // remainder follows the dividend sign
            if (rem_sel) begin
                res <= neg_r ? -rem_r : rem_r;
            end else begin
                res <= neg_q ? -quo : quo;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            fixup <= 1'b0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            if (abort) begin
                busy  <= 1'b0;
                fixup <= 1'b0;
            end else if (start) begin
                if (div_zero || overflow) begin
                    done <= 1'b1;
                end else begin
                    busy <= 1'b1;
                end
            end else if (busy && (count == '0)) begin
                busy  <= 1'b0;
                fixup <= 1'b1;
            end else if (fixup) begin
                fixup <= 1'b0;
                done  <= 1'b1;
            end
        end
    end

endmodule

//--- hdl/mul_unit.sv
module mul_unit #(
    parameter int xlen = 64
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    input  logic            abort,
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    output logic            done,
    output logic [xlen-1:0] res
);
    localparam int cnt_w = $clog2(xlen);

    typedef logic [xlen-1:0]  word_t;
    typedef logic [cnt_w-1:0] count_t;

    word_t  mcand;
    word_t  mplier;
    word_t  acc;
    count_t count;
    logic   busy;

    // accumulator holds the product once done pulses
    assign res = acc;

    // one multiplier bit per cycle, lsb first
    always_ff @(posedge clk) begin
        if (start && !abort) begin
            mcand  <= a;
            mplier <= b;
            acc    <= '0;
            count  <= count_t'(xlen - 1);
        end else if (busy) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            // bits shifted out of the top never reach the low word
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
            count  <= count - count_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (abort) begin
                busy <= 1'b0;
            end else if (start) begin
                busy <= 1'b1;
            end else if (busy && (count == '0)) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

endmodule

//--- hdl/alu_core.sv
module alu_core #(
    parameter int xlen = 64
) (
    input  exec_pkg::alu_op_t op,
    input  exec_pkg::src_a_t  sel_a,
    input  exec_pkg::src_b_t  sel_b,
    input  logic              w32,
    input  logic [xlen-1:0]   pc,
    input  logic [xlen-1:0]   rs1,
    input  logic [xlen-1:0]   rs2,
    input  logic [xlen-1:0]   csr,
    input  logic [xlen-1:0]   imm,
    output logic [xlen-1:0]   a,
    output logic [xlen-1:0]   b,
    output logic [xlen-1:0]   res
);
    import exec_pkg::*;

    localparam int shamt_w = $clog2(xlen);

    typedef logic [xlen-1:0]   word_t;
    typedef logic [xlen/2-1:0] half_t;
    typedef logic [shamt_w-1:0] shamt_t;

    word_t  rs1_eff;
    shamt_t shamt;
    half_t  sra_half;

    // word mode keeps only the low half of rs1
    assign rs1_eff = w32 ? {{(xlen/2){1'b0}}, rs1[xlen/2-1:0]} : rs1;

    assign a = (sel_a == src_a_rs1) ? rs1_eff : pc;

    always_comb begin
        case (sel_b)
            src_b_rs2: b = rs2;
            src_b_csr: b = csr;
            default:   b = imm;
        endcase
    end

    assign shamt = b[shamt_w-1:0];

    // signed shift of the low half, used by w32 sra
    assign sra_half = $signed(a[xlen/2-1:0]) >>> shamt;

    always_comb begin
        case (op)
            op_add: begin
                res = a + b;
            end
            op_sub: begin
                res = a - b;
            end
            op_pass_a: begin
                res = a;
            end
            op_pass_b: begin
                res = b;
            end
            op_xor: begin
                res = a ^ b;
            end
            op_or: begin
                res = a | b;
            end
            op_and: begin
                res = a & b;
            end
            op_sll: begin
                res = a << shamt;
            end
            op_srl: begin
                res = a >> shamt;
            end
            op_sra: begin
                // word result is zero-extended, not sign-extended
                if (w32) begin
                    res = {{(xlen/2){1'b0}}, sra_half};
                end else begin
                    res = word_t'($signed(a) >>> shamt);
                end
            end
            op_slt: begin
                res = word_t'($signed(a) < $signed(b));
            end
            op_sltu: begin
                res = word_t'(a < b);
            end
            op_eq: begin
                res = word_t'(a == b);
            end
            op_ge: begin
                res = word_t'($signed(a) >= $signed(b));
            end
            op_geu: begin
                res = word_t'(a >= b);
            end
            // mul, div family and unused codes
            default: begin
                res = '0;
            end
        endcase
    end

endmodule

//--- hdl/exec_pkg.sv
package exec_pkg;

    // operation codes carried with each request
    typedef enum logic [4:0] {
        op_add    = 5'd0,
        op_sub    = 5'd1,
        op_pass_a = 5'd2,
        op_pass_b = 5'd3,
        op_xor    = 5'd4,
        op_or     = 5'd5,
        op_and    = 5'd6,
        op_sll    = 5'd7,
        op_srl    = 5'd8,
        op_sra    = 5'd9,
        op_slt    = 5'd10,
        op_sltu   = 5'd11,
        op_eq     = 5'd12,
        op_ge     = 5'd13,
        op_geu    = 5'd14,
        // iterative units from here on
        op_mul    = 5'd15,
        op_div    = 5'd16,
        op_divu   = 5'd17,
        op_rem    = 5'd18,
        op_remu   = 5'd19
    } alu_op_t;

    // first operand source
    typedef enum logic {
        src_a_pc  = 1'b0,
        src_a_rs1 = 1'b1
    } src_a_t;

    // second operand source, 2'b11 falls back to imm
    typedef enum logic [1:0] {
        src_b_rs2 = 2'd1,
        src_b_csr = 2'd2,
        src_b_imm = 2'd0
    } src_b_t;

    // controller states
    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_busy = 2'd1,
        st_done = 2'd2
    } ctrl_state_t;

    // divider family, signed or unsigned, quotient or remainder
    function automatic logic op_is_div(alu_op_t op);
        return op inside {op_div, op_divu, op_rem, op_remu};
    endfunction

    // anything that needs mul_unit or div_unit
    function automatic logic op_is_multi(alu_op_t op);
        return (op == op_mul) || op_is_div(op);
    endfunction

endpackage
